// ==== mipsCpuBus.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/decodeIf.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/execStage.sv
hdl/cpuControl.sv
hdl/mipsCpuBus.sv
dv/avalonMemModel.sv
dv/tb_mipsCpuBus.sv

// ==== Makefile ====
TOP := tb_mipsCpuBus

all: run

build:
	verilator --binary --timing --assert -j 0 -f mipsCpuBus.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing --assert -f mipsCpuBus.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== dv/tb_mipsCpuBus.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module tb_mipsCpuBus;
    localparam int          ClkPeriod   = 100;
    localparam int          MemWords    = 64;
    localparam int          StallPct    = 30;
    localparam int          CycleBudget = 200;  // Per program including stalls
    localparam int          NumRows     = 26;
    localparam logic [31:0] DataBase    = 32'h0000_1000;
    localparam logic [25:0] JumpField   = 26'((`RESET_VECTOR + 32'd20) >> 2);

    typedef enum logic [4:0] {
        K_ADDU, K_SUBU, K_AND, K_OR, K_XOR, K_SLT, K_SLTU,
        K_ADDIU, K_SLTI, K_SLTIU, K_ANDI, K_ORI, K_XORI, K_LUI,
        K_SW, K_BEQ, K_BNE, K_J
    } kindT;

    typedef struct packed {
        kindT        kind;
        logic [31:0] a;
        logic [31:0] b;
        logic        slotWrite;  // JR delay slot bumps v0
    } rowT;

    rowT rows [NumRows] = '{
        '{K_ADDU,  32'h7FFF_FFFF, 32'h0000_0001, 1'b0},
        '{K_ADDU,  32'hFFFF_FFFF, 32'h0000_0003, 1'b1},
        '{K_SUBU,  32'h0000_0005, 32'h0000_0009, 1'b0},
        '{K_AND,   32'hF0F0_FF00, 32'h0FF0_F0F0, 1'b0},
        '{K_OR,    32'hF0F0_FF00, 32'h0FF0_F0F0, 1'b1},
        '{K_XOR,   32'hF0F0_FF00, 32'h0FF0_F0F0, 1'b0},
        '{K_SLT,   32'h8000_0000, 32'h0000_0001, 1'b0},
        '{K_SLT,   32'h0000_0005, 32'hFFFF_FFFB, 1'b1},
        '{K_SLTU,  32'h8000_0000, 32'h0000_0001, 1'b0},
        '{K_SLTU,  32'h0000_0001, 32'h8000_0000, 1'b0},
        '{K_ADDIU, 32'h0000_0010, 32'h0000_FFF0, 1'b0},
        '{K_ADDIU, 32'h1234_5678, 32'h0000_1111, 1'b1},
        '{K_ANDI,  32'hFFFF_FFFF, 32'h0000_8001, 1'b0},
        '{K_ORI,   32'h1234_0000, 32'h0000_8000, 1'b0},
        '{K_XORI,  32'hFFFF_0000, 32'h0000_FFFF, 1'b1},
        '{K_SLTI,  32'hFFFF_FFF0, 32'h0000_0005, 1'b0},
        '{K_SLTI,  32'h0000_0005, 32'h0000_FFFF, 1'b0},
        '{K_SLTIU, 32'h0001_0000, 32'h0000_FFFF, 1'b0},
        '{K_LUI,   32'h0000_0000, 32'h0000_ABCD, 1'b1},
        '{K_SW,    32'h1111_1111, 32'h2222_2222, 1'b1},
        '{K_BEQ,   32'h0000_0007, 32'h0000_0007, 1'b0},
        '{K_BEQ,   32'h0000_0007, 32'h0000_0008, 1'b1},
        '{K_BNE,   32'h0000_0007, 32'h0000_0008, 1'b0},
        '{K_BNE,   32'h0000_0003, 32'h0000_0003, 1'b1},
        '{K_J,     32'h0000_0000, 32'h0000_0000, 1'b1},
        '{K_J,     32'h0000_0000, 32'h0000_0000, 1'b0}
    };

    logic        clk, rst, active, read, write, waitrequest;
    logic [31:0] register_v0, address, writedata, readdata;
    logic [3:0]  byteenable;
    int          errCount = 0;
    int          checkCount = 0;

    mipsCpuBus u_mipsCpuBus (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalonMemModel #(
        .MemWords (MemWords),
        .StallPct (StallPct),
        .DataBase (DataBase)
    ) u_memModel (
        .clk         (clk),
        .read        (read),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (got !== expected) begin
            errCount++;
            $display("ERR @%0t: %s got %h, expected %h", $time, what, got, expected);
        end
    endtask

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Function code for R-format kinds and opcode for the rest
    function automatic logic [5:0] encoding(input kindT k);
        case (k)
            K_ADDU:  return 6'h21;
            K_SUBU:  return 6'h23;
            K_AND:   return 6'h24;
            K_OR:    return 6'h25;
            K_XOR:   return 6'h26;
            K_SLT:   return 6'h2A;
            K_SLTU:  return 6'h2B;
            K_ADDIU: return 6'h09;
            K_SLTI:  return 6'h0A;
            K_SLTIU: return 6'h0B;
            K_ANDI:  return 6'h0C;
            K_ORI:   return 6'h0D;
            K_XORI:  return 6'h0E;
            K_LUI:   return 6'h0F;
            K_BEQ:   return 6'h04;
            K_BNE:   return 6'h05;
            default: return 6'h00;
        endcase
    endfunction

    function automatic logic [31:0] expectedV0(input rowT r);
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] v;
        sx = {{16{r.b[15]}}, r.b[15:0]};
        zx = {16'h0000, r.b[15:0]};
        case (r.kind)
            K_ADDU:  v = r.a + r.b;
            K_SUBU:  v = r.a - r.b;
            K_AND:   v = r.a & r.b;
            K_OR:    v = r.a | r.b;
            K_XOR:   v = r.a ^ r.b;
            K_SLT:   v = {31'b0, $signed(r.a) < $signed(r.b)};
            K_SLTU:  v = {31'b0, r.a < r.b};
            K_ADDIU: v = r.a + sx;
            K_SLTI:  v = {31'b0, $signed(r.a) < $signed(sx)};
            K_SLTIU: v = {31'b0, r.a < sx};
            K_ANDI:  v = r.a & zx;
            K_ORI:   v = r.a | zx;
            K_XORI:  v = r.a ^ zx;
            K_LUI:   v = {r.b[15:0], 16'h0000};
            K_SW:    v = r.a + r.b;
            K_BEQ:   v = r.a == r.b ? 32'h11 : 32'h111;  // Skipped add only when not taken
            K_BNE:   v = r.a != r.b ? 32'h11 : 32'h111;
            K_J:     v = 32'h22;
            default: v = 32'h0;
        endcase
        return v + 32'(r.slotWrite);
    endfunction

    task automatic buildProgram(input rowT r);
        int pos;
        for (int i = 0; i < MemWords; i++) begin
            u_memModel.codeMem[i] = 32'h0000_0000;  // NOP
            u_memModel.dataMem[i] = (DataBase + 32'(4 * i)) ^ 32'hC3A5_5A3C;
        end
        u_memModel.dataMem[0] = r.a;
        u_memModel.dataMem[1] = r.b;
        u_memModel.codeMem[0] = iType(6'h23, 5'd0, 5'd8, DataBase[15:0]);
        u_memModel.codeMem[1] = iType(6'h23, 5'd0, 5'd9, DataBase[15:0] + 16'd4);
        pos = 3;
        if (r.kind <= K_SLTU) begin
            u_memModel.codeMem[2] = rType(encoding(r.kind), 5'd8, 5'd9, 5'd2);
        end else if (r.kind == K_LUI) begin
            u_memModel.codeMem[2] = iType(6'h0F, 5'd0, 5'd2, r.b[15:0]);
        end else if (r.kind < K_LUI) begin
            u_memModel.codeMem[2] = iType(encoding(r.kind), 5'd8, 5'd2, r.b[15:0]);
        end else if (r.kind == K_SW) begin
            u_memModel.codeMem[2] = rType(6'h21, 5'd8, 5'd9, 5'd2);
            u_memModel.codeMem[3] = iType(6'h2B, 5'd0, 5'd2, DataBase[15:0] + 16'd8);
            pos = 4;
        end else begin
            // Branch or jump to word 5 past word 4
            u_memModel.codeMem[2] = r.kind == K_J ? {6'h02, JumpField}
                                                  : iType(encoding(r.kind), 5'd8, 5'd9, 16'd2);
            u_memModel.codeMem[3] = iType(6'h09, 5'd0, 5'd2, r.kind == K_J ? 16'h22 : 16'h11);
            u_memModel.codeMem[4] = iType(6'h09, 5'd2, 5'd2, 16'h0100);
            pos = 5;
        end
        u_memModel.codeMem[pos] = rType(6'h08, 5'd0, 5'd0, 5'd0);  // JR r0 halts
        u_memModel.codeMem[pos + 1] = r.slotWrite ? iType(6'h09, 5'd2, 5'd2, 16'h0001)
                                                  : 32'h0000_0000;
    endtask

    task automatic watchBus();
        if (read || write) begin
            checkValue(32'(byteenable), 32'hF, "byteenable during access");
        end else begin
            checkValue(32'(byteenable), 32'h0, "byteenable when idle");
        end
        if (!active) begin
            checkValue(32'({read, write}), 32'h0, "bus activity after halt");
        end
    endtask

    task automatic runRow(input rowT r, input int idx);
        @(posedge clk);
        #10 rst = 1'b1;
        buildProgram(r);
        repeat (5) @(posedge clk);
        #10 rst = 1'b0;
        @(negedge clk);
        checkValue(address, `RESET_VECTOR, $sformatf("row %0d first fetch address", idx));
        checkValue(32'({read, write}), 32'h2, $sformatf("row %0d first fetch strobes", idx));
        watchBus();
        do begin
            @(negedge clk);
            watchBus();
        end while (active);
        repeat (3) begin
            @(negedge clk);
            watchBus();
        end
        checkValue(register_v0, expectedV0(r), $sformatf("row %0d register_v0", idx));
        if (r.kind == K_SW) begin
            checkValue(u_memModel.dataMem[2], r.a + r.b, $sformatf("row %0d stored word", idx));
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int i = 0; i < NumRows; i++) begin
            runRow(rows[i], i);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(NumRows * CycleBudget * ClkPeriod);
        $display("Timeout: the CPU did not halt within %0d cycles per program", CycleBudget);
        $display("Simulation failed");
        $finish;
    end
endmodule

// ==== dv/avalonMemModel.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module avalonMemModel #(
    parameter int          MemWords = 64,
    parameter int          StallPct = 30,
    parameter logic [31:0] DataBase = 32'h0000_1000
) (
    input  logic        clk,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] address,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);
    logic [31:0] codeMem [MemWords];  // Mapped at the reset vector
    logic [31:0] dataMem [MemWords];
    logic [31:0] seed;

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] readWord(input logic [31:0] addr);
        int codeIdx;
        int dataIdx;
        codeIdx = int'((addr - `RESET_VECTOR) >> 2);
        dataIdx = int'((addr - DataBase) >> 2);
        if (codeIdx < MemWords) begin
            return codeMem[codeIdx];
        end else if (dataIdx < MemWords) begin
            return dataMem[dataIdx];
        end
        return addr ^ 32'hDEAD_BEEF;  // Unmapped
    endfunction

    initial begin
        int dataIdx;
        seed        = 32'd43;
        waitrequest = 1'b0;
        readdata    = 32'h0000_0000;
        forever begin
            @(posedge clk);
            #10;
            seed        = lcgStep(seed);
            waitrequest = ((seed >> 16) % 32'd100) < 32'(StallPct);
            readdata    = read ? readWord(address) : 32'h0000_0000;
            @(negedge clk);
            // Store lands in the cycle the bus accepts it
            if (write && !waitrequest) begin
                dataIdx = int'((address - DataBase) >> 2);
                if (dataIdx < MemWords) begin
                    dataMem[dataIdx] = writedata;
                end
            end
        end
    end
endmodule

// ==== hdl/mipsCpuBus.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module mipsCpuBus (
    input  logic               clk,
    input  logic               rst,
    output logic               active,
    output logic [`WORD_W-1:0] register_v0,
    output logic [`WORD_W-1:0] address,
    output logic               write,
    output logic               read,
    input  logic               waitrequest,
    output logic [`WORD_W-1:0] writedata,
    output logic [3:0]         byteenable,
    input  logic [`WORD_W-1:0] readdata
);
    cpuPkg::cpuStateT       state;
    logic [`WORD_W-1:0]     instr, aluResult, jumpRegTarget;
    logic [`WORD_W-1:0]     rdDataA, rdDataB, regWrData;
    logic [`REG_ADDR_W-1:0] rdAddrA, rdAddrB, regWrAddr;
    logic                   branchTaken, regWrEn;

    decodeIf decBus ();

    instrDecoder u_instrDecoder (
        .instr (instr),
        .dec   (decBus.decoder)
    );

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .wrEn    (regWrEn),
        .wrAddr  (regWrAddr),
        .wrData  (regWrData),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .regV0   (register_v0)
    );

    execStage u_execStage (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .dec           (decBus.exec),
        .rdDataA       (rdDataA),
        .rdDataB       (rdDataB),
        .memData       (readdata),
        .aluResult     (aluResult),
        .storeData     (writedata),
        .jumpRegTarget (jumpRegTarget),
        .branchTaken   (branchTaken),
        .regWrEn       (regWrEn),
        .regWrAddr     (regWrAddr),
        .regWrData     (regWrData)
    );

    cpuControl u_cpuControl (
        .clk           (clk),
        .rst           (rst),
        .dec           (decBus.control),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .aluResult     (aluResult),
        .branchTaken   (branchTaken),
        .jumpRegTarget (jumpRegTarget),
        .state         (state),
        .instr         (instr),
        .rdAddrA       (rdAddrA),
        .rdAddrB       (rdAddrB),
        .active        (active),
        .read          (read),
        .write         (write),
        .address       (address),
        .byteenable    (byteenable)
    );
endmodule

// ==== hdl/cpuControl.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module cpuControl (
    input  logic                   clk,
    input  logic                   rst,
    decodeIf.control               dec,
    input  logic                   waitrequest,
    input  logic [`WORD_W-1:0]     readdata,
    input  logic [`WORD_W-1:0]     aluResult,
    input  logic                   branchTaken,
    input  logic [`WORD_W-1:0]     jumpRegTarget,
    output cpuPkg::cpuStateT       state,
    output logic [`WORD_W-1:0]     instr,
    output logic [`REG_ADDR_W-1:0] rdAddrA,
    output logic [`REG_ADDR_W-1:0] rdAddrB,
    output logic                   active,
    output logic                   read,
    output logic                   write,
    output logic [`WORD_W-1:0]     address,
    output logic [3:0]             byteenable
);
    logic [`WORD_W-1:0] pc, slotAddr, nextTarget, savedTarget;
    logic [1:0]         pendStep;  // 1 = taken, 2 = delay slot running
    logic               memAccess;

    assign slotAddr  = pc + `WORD_W'(4);
    assign memAccess = dec.memRead || dec.memWrite;
    assign rdAddrA   = dec.rs;
    assign rdAddrB   = dec.rt;

    assign read       = (state == cpuPkg::FETCH && pc != `HALT_ADDR) ||
                        (state == cpuPkg::MEM && dec.memRead);
    assign write      = state == cpuPkg::MEM && dec.memWrite;
    assign address    = state == cpuPkg::FETCH ? pc : aluResult;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    always_comb begin
        if (dec.jumpReg) begin
            nextTarget = jumpRegTarget;
        end else if (dec.jump) begin
            nextTarget = {slotAddr[31:28], dec.target, 2'b00};
        end else begin
            // Branch offset is the low half of the target field
            nextTarget = slotAddr + {{(`WORD_W-18){dec.target[15]}}, dec.target[15:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= cpuPkg::FETCH;
            pc       <= `RESET_VECTOR;
            active   <= 1'b1;
            pendStep <= 2'd0;
        end else begin
            case (state)
                cpuPkg::FETCH: begin
                    if (pc == `HALT_ADDR) begin
                        state  <= cpuPkg::HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= cpuPkg::DECODE;
                    end
                end
                cpuPkg::DECODE: state <= cpuPkg::EXEC;
                cpuPkg::EXEC:   state <= cpuPkg::MEM;
                cpuPkg::MEM: begin
                    if (!(memAccess && waitrequest)) begin
                        state <= cpuPkg::WRITE_BACK;
                    end
                    if (branchTaken || dec.jump || dec.jumpReg) begin
                        pendStep <= 2'd1;
                    end
                end
                cpuPkg::WRITE_BACK: begin
                    state <= cpuPkg::FETCH;
                    if (pendStep == 2'd2) begin  // Delay slot done, redirect
                        pc       <= savedTarget;
                        pendStep <= 2'd0;
                    end else begin
                        pc <= slotAddr;
                        if (pendStep == 2'd1) begin
                            pendStep <= 2'd2;
                        end
                    end
                end
                default: state <= cpuPkg::HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpuPkg::FETCH && !waitrequest) begin
            instr <= readdata;
        end
        if (state == cpuPkg::MEM && (branchTaken || dec.jump || dec.jumpReg)) begin
            savedTarget <= nextTarget;
        end
    end

    // Decoder never flags a load and a store together
    assert property (@(posedge clk) disable iff (rst) !(read && write));

    assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=> $stable(address) && $stable({read, write}));
endmodule

// ==== hdl/execStage.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module execStage (
    input  logic                   clk,
    input  logic                   rst,
    input  cpuPkg::cpuStateT       state,
    decodeIf.exec                  dec,
    input  logic [`WORD_W-1:0]     rdDataA,
    input  logic [`WORD_W-1:0]     rdDataB,
    input  logic [`WORD_W-1:0]     memData,
    output logic [`WORD_W-1:0]     aluResult,
    output logic [`WORD_W-1:0]     storeData,
    output logic [`WORD_W-1:0]     jumpRegTarget,
    output logic                   branchTaken,
    output logic                   regWrEn,
    output logic [`REG_ADDR_W-1:0] regWrAddr,
    output logic [`WORD_W-1:0]     regWrData
);
    logic [`WORD_W-1:0] opA, opB, immExt, loadData;
    logic               aluZero;

    assign immExt = dec.zeroExtImm ? {{(`WORD_W-16){1'b0}}, dec.imm}
                                   : {{(`WORD_W-16){dec.imm[15]}}, dec.imm};

    always_ff @(posedge clk) begin
        if (rst) begin
            opA       <= '0;
            opB       <= '0;
            storeData <= '0;
        end else if (state == cpuPkg::EXEC) begin
            opA       <= rdDataA;
            opB       <= dec.useImm ? immExt : rdDataB;
            storeData <= rdDataB;  // rt value for SW
        end
    end

    // Last MEM cycle is the one the bus accepted
    always_ff @(posedge clk) begin
        if (state == cpuPkg::MEM) begin
            loadData <= memData;
        end
    end

    alu u_alu (
        .op     (dec.aluOp),
        .a      (opA),
        .b      (opB),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign jumpRegTarget = opA;
    assign branchTaken   = state == cpuPkg::MEM &&
                           ((dec.branchEq && aluZero) || (dec.branchNe && !aluZero));

    assign regWrEn   = state == cpuPkg::WRITE_BACK && dec.regWrite;
    assign regWrAddr = dec.destIsRd ? dec.rd : dec.rt;
    assign regWrData = dec.memRead ? loadData : aluResult;
endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module alu (
    input  cpuPkg::aluOpT      op,
    input  logic [`WORD_W-1:0] a,
    input  logic [`WORD_W-1:0] b,
    output logic [`WORD_W-1:0] result,
    output logic               zero
);
    always_comb begin
        case (op)
            cpuPkg::ALU_AND:    result = a & b;
            cpuPkg::ALU_OR:     result = a | b;
            cpuPkg::ALU_XOR:    result = a ^ b;
            cpuPkg::ALU_ADD:    result = a + b;
            cpuPkg::ALU_SUB:    result = a - b;
            cpuPkg::ALU_SLT:    result = {{(`WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
            cpuPkg::ALU_SLTU:   result = {{(`WORD_W-1){1'b0}}, a < b};
            cpuPkg::ALU_LUI:    result = {b[15:0], 16'h0000};
            cpuPkg::ALU_PASS_A: result = a;
            default:            result = '0;
        endcase
    end

    assign zero = result == '0;
endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wrEn,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic [`WORD_W-1:0]     wrData,
    input  logic [`REG_ADDR_W-1:0] rdAddrA,
    input  logic [`REG_ADDR_W-1:0] rdAddrB,
    output logic [`WORD_W-1:0]     rdDataA,
    output logic [`WORD_W-1:0]     rdDataB,
    output logic [`WORD_W-1:0]     regV0
);
    localparam int NumRegs = 1 << `REG_ADDR_W;

    logic [`WORD_W-1:0] regs [NumRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin // r0 stays zero
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign regV0   = regs[`V0_REG];

    // Destination comes from the decoder through the exec stage
    assert property (@(posedge clk) disable iff (rst) wrEn |-> !$isunknown(wrAddr));
endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

module instrDecoder (
    input logic [`WORD_W-1:0] instr,
    decodeIf.decoder          dec
);
    cpuPkg::opcodeT opcode;
    cpuPkg::funcT   func;

    assign opcode = cpuPkg::opcodeT'(instr[31:26]);
    assign func   = cpuPkg::funcT'(instr[5:0]);

    assign dec.rs     = instr[25:21];
    assign dec.rt     = instr[20:16];
    assign dec.rd     = instr[15:11];
    assign dec.imm    = instr[15:0];
    assign dec.target = instr[25:0];

    always_comb begin
        // Immediate ALU op writing rt unless overridden below
        dec.aluOp      = cpuPkg::ALU_ADD;
        dec.useImm     = 1'b1;
        dec.zeroExtImm = opcode inside {cpuPkg::OP_ANDI, cpuPkg::OP_ORI,
                                        cpuPkg::OP_XORI, cpuPkg::OP_LUI};
        dec.regWrite   = 1'b1;
        dec.destIsRd   = 1'b0;
        dec.memRead    = 1'b0;
        dec.memWrite   = 1'b0;
        dec.branchEq   = 1'b0;
        dec.branchNe   = 1'b0;
        dec.jump       = 1'b0;
        dec.jumpReg    = 1'b0;
        case (opcode)
            cpuPkg::OP_RTYPE: begin
                dec.useImm   = 1'b0;
                dec.destIsRd = 1'b1;
                case (func)
                    cpuPkg::FN_ADDU: dec.aluOp = cpuPkg::ALU_ADD;
                    cpuPkg::FN_SUBU: dec.aluOp = cpuPkg::ALU_SUB;
                    cpuPkg::FN_AND:  dec.aluOp = cpuPkg::ALU_AND;
                    cpuPkg::FN_OR:   dec.aluOp = cpuPkg::ALU_OR;
                    cpuPkg::FN_XOR:  dec.aluOp = cpuPkg::ALU_XOR;
                    cpuPkg::FN_SLT:  dec.aluOp = cpuPkg::ALU_SLT;
                    cpuPkg::FN_SLTU: dec.aluOp = cpuPkg::ALU_SLTU;
                    cpuPkg::FN_JR: begin
                        dec.aluOp    = cpuPkg::ALU_PASS_A;
                        dec.regWrite = 1'b0;
                        dec.jumpReg  = 1'b1;
                    end
                    default: dec.regWrite = 1'b0;
                endcase
            end
            cpuPkg::OP_ADDIU: dec.aluOp = cpuPkg::ALU_ADD;
            cpuPkg::OP_SLTI:  dec.aluOp = cpuPkg::ALU_SLT;
            cpuPkg::OP_SLTIU: dec.aluOp = cpuPkg::ALU_SLTU; // Sign-extended, unsigned compare
            cpuPkg::OP_ANDI:  dec.aluOp = cpuPkg::ALU_AND;
            cpuPkg::OP_ORI:   dec.aluOp = cpuPkg::ALU_OR;
            cpuPkg::OP_XORI:  dec.aluOp = cpuPkg::ALU_XOR;
            cpuPkg::OP_LUI:   dec.aluOp = cpuPkg::ALU_LUI;
            cpuPkg::OP_LW:    dec.memRead = 1'b1;
            cpuPkg::OP_SW: begin
                dec.regWrite = 1'b0;
                dec.memWrite = 1'b1;
            end
            cpuPkg::OP_BEQ, cpuPkg::OP_BNE: begin
                dec.aluOp    = cpuPkg::ALU_SUB;  // Zero flag gives equality
                dec.useImm   = 1'b0;
                dec.regWrite = 1'b0;
                dec.branchEq = opcode == cpuPkg::OP_BEQ;
                dec.branchNe = opcode == cpuPkg::OP_BNE;
            end
            cpuPkg::OP_J: begin
                dec.aluOp    = cpuPkg::ALU_PASS_A;
                dec.regWrite = 1'b0;
                dec.jump     = 1'b1;
            end
            default: dec.regWrite = 1'b0;
        endcase
    end
endmodule

// ==== hdl/decodeIf.sv ====
`timescale 1ns/10ps
`include "cpuMacros.svh"

interface decodeIf;
    cpuPkg::aluOpT aluOp;
    logic useImm, zeroExtImm, regWrite, destIsRd;
    logic memRead, memWrite;
    logic branchEq, branchNe, jump, jumpReg;
    logic [`REG_ADDR_W-1:0] rs, rt, rd;
    logic [15:0] imm;
    logic [25:0] target;

    modport decoder (output aluOp, useImm, zeroExtImm, regWrite, destIsRd, memRead,
                     memWrite, branchEq, branchNe, jump, jumpReg, rs, rt, rd, imm, target);

    // memRead picks the loaded word at write-back
    modport exec (input aluOp, useImm, zeroExtImm, regWrite, destIsRd, memRead,
                  branchEq, branchNe, rt, rd, imm);

    modport control (input memRead, memWrite, jump, jumpReg, rs, rt, target);
endinterface

// ==== hdl/cpuPkg.sv ====
package cpuPkg;

    // Primary opcodes, R-format is zero
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funcT;

    typedef enum logic [3:0] {
        ALU_AND, ALU_OR, ALU_ADD, ALU_SUB, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_LUI, ALU_PASS_A
    } aluOpT;

    typedef enum logic [2:0] {
        FETCH      = 3'd0,
        DECODE     = 3'd1,
        EXEC       = 3'd2,
        MEM        = 3'd3,
        WRITE_BACK = 3'd4,
        HALTED     = 3'd7
    } cpuStateT;

endpackage

// ==== hdl/cpuMacros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and address width
`define WORD_W 32
`define REG_ADDR_W 5

// First fetch after reset
`define RESET_VECTOR 32'hBFC0_0000

`define V0_REG 2

// Fetching from here stops the CPU
`define HALT_ADDR 32'h0000_0000

`endif
